/* exec_pkg.sv */
// Shared RV32I execute types; only the kept opcode classes are encoded, all else decodes illegal
package exec_pkg;

    // One data or address word
    typedef logic [31:0] word_t;

    // Register index as it sits in the instruction word
    typedef logic [4:0] reg_idx_t;

    // Major opcodes of the supported classes
    typedef enum logic [6:0] {
        opc_load   = 7'b0000011,
        opc_op_imm = 7'b0010011,
        opc_auipc  = 7'b0010111,
        opc_store  = 7'b0100011,
        opc_op     = 7'b0110011,
        opc_lui    = 7'b0110111,
        opc_branch = 7'b1100011,
        opc_jalr   = 7'b1100111,
        opc_jal    = 7'b1101111
    } opcode_e;

    // Low three bits follow funct3, bit 3 marks the alternate form
    typedef enum logic [3:0] {
        alu_add  = 4'b0000,
        alu_sll  = 4'b0001,
        alu_slt  = 4'b0010,
        alu_sltu = 4'b0011,
        alu_xor  = 4'b0100,
        alu_srl  = 4'b0101,
        alu_or   = 4'b0110,
        alu_and  = 4'b0111,
        alu_sub  = 4'b1000,
        alu_sra  = 4'b1101
    } alu_op_e;

    // Same encoding as funct3 of the branch opcode
    typedef enum logic [2:0] {
        br_beq  = 3'b000,
        br_bne  = 3'b001,
        br_blt  = 3'b100,
        br_bge  = 3'b101,
        br_bltu = 3'b110,
        br_bgeu = 3'b111
    } branch_type_e;

    // Operand A source
    typedef enum logic [1:0] {
        a_rs1  = 2'd0,
        a_pc   = 2'd1,
        a_zero = 2'd2
    } a_sel_e;

    // Operand B source
    typedef enum logic [2:0] {
        b_rs2   = 3'd0,
        b_imm_i = 3'd1,
        b_imm_s = 3'd2,
        b_imm_u = 3'd3,
        b_four  = 3'd4
    } b_sel_e;

    // Fixed PC step, no compressed instructions
    localparam word_t instr_bytes = 32'd4;

endpackage

/* decode_if.sv */
// Decoded control bundle; immediates are full sign-extended words, shift amounts sit in imm_i
interface decode_if import exec_pkg::*; ();

    // ALU and operand selection
    alu_op_e      alu_op;
    a_sel_e       a_sel;
    b_sel_e       b_sel;

    // Register indices
    reg_idx_t     rs1;
    reg_idx_t     rs2;
    reg_idx_t     rd;

    // Immediates, already extended
    word_t        imm_i;
    word_t        imm_s;
    word_t        imm_b;
    word_t        imm_u;
    word_t        imm_j;

    // Control flow
    logic         is_branch;
    logic         is_jal;
    logic         is_jalr;
    branch_type_e branch_type;

    // Side effects for later stages
    logic         reg_write;
    logic         dren;
    logic         dwen;
    logic         illegal;

    modport decoder (output alu_op, a_sel, b_sel, rs1, rs2, rd, imm_i, imm_s, imm_b, imm_u,
                     imm_j, is_branch, is_jal, is_jalr, branch_type, reg_write, dren, dwen,
                     illegal);
    modport operands (input a_sel, b_sel, imm_i, imm_s, imm_u);
    modport alu (input alu_op);
    modport branch (input is_branch, is_jal, is_jalr, branch_type, imm_i, imm_b, imm_j);
    modport pipe (input rd, reg_write, dren, dwen, is_branch, is_jal, is_jalr, illegal);

endinterface

/* control_decoder.sv */
// RV32I decoder for OP, OP-IMM, LUI, AUIPC, JAL, JALR, branches, loads and stores only
module control_decoder import exec_pkg::*; (
    input word_t       instr,
    decode_if.decoder  dec
);

    opcode_e    opcode;
    logic [2:0] funct3;

    // Map funct3 and bit 30 onto an ALU operation
    function automatic alu_op_e arith_op(logic [2:0] f3, logic alt, logic is_reg);
        case (f3)
            3'b000:  return (alt && is_reg) ? alu_sub : alu_add;
            3'b001:  return alu_sll;
            3'b010:  return alu_slt;
            3'b011:  return alu_sltu;
            3'b100:  return alu_xor;
            3'b101:  return alt ? alu_sra : alu_srl;
            3'b110:  return alu_or;
            default: return alu_and;
        endcase
    endfunction

    assign opcode = opcode_e'(instr[6:0]);
    assign funct3 = instr[14:12];

    // Fixed field positions
    assign dec.rd          = instr[11:7];
    assign dec.rs1         = instr[19:15];
    assign dec.rs2         = instr[24:20];
    assign dec.branch_type = branch_type_e'(funct3);

    // Immediate formats, sign taken from bit 31
    assign dec.imm_i = {{20{instr[31]}}, instr[31:20]};
    assign dec.imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign dec.imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign dec.imm_u = {instr[31:12], 12'b0};
    assign dec.imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        // Defaults describe a harmless add with nothing enabled
        dec.alu_op    = alu_add;
        dec.a_sel     = a_rs1;
        dec.b_sel     = b_rs2;
        dec.is_branch = 1'b0;
        dec.is_jal    = 1'b0;
        dec.is_jalr   = 1'b0;
        dec.reg_write = 1'b0;
        dec.dren      = 1'b0;
        dec.dwen      = 1'b0;
        dec.illegal   = 1'b0;
        case (opcode)
            opc_op: begin
                dec.reg_write = 1'b1;
                dec.alu_op    = arith_op(funct3, instr[30], 1'b1);
            end
            opc_op_imm: begin
                dec.reg_write = 1'b1;
                dec.b_sel     = b_imm_i;
                dec.alu_op    = arith_op(funct3, instr[30], 1'b0);
            end
            opc_load: begin
                dec.reg_write = 1'b1;
                dec.dren      = 1'b1;
                dec.b_sel     = b_imm_i;
            end
            opc_store: begin
                dec.dwen  = 1'b1;
                dec.b_sel = b_imm_s;
            end
            opc_lui: begin
                dec.reg_write = 1'b1;
                dec.a_sel     = a_zero;
                dec.b_sel     = b_imm_u;
            end
            opc_auipc: begin
                dec.reg_write = 1'b1;
                dec.a_sel     = a_pc;
                dec.b_sel     = b_imm_u;
            end
            // Link value is pc plus four through the ALU
            opc_jal, opc_jalr: begin
                dec.reg_write = 1'b1;
                dec.is_jal    = (opcode == opc_jal);
                dec.is_jalr   = (opcode == opc_jalr);
                dec.a_sel     = a_pc;
                dec.b_sel     = b_four;
            end
            // Condition is resolved in the branch unit, ALU result unused
            opc_branch: dec.is_branch = 1'b1;
            default:    dec.illegal   = 1'b1;
        endcase
    end

endmodule

/* reg_file.sv */
// Integer register file; x0 and indices at or above reg_count read zero, contents reset to zero
module reg_file import exec_pkg::*; #(
    parameter int reg_count = 32
) (
    input  logic     CLK,
    input  logic     nRST,
    input  logic     wen,
    input  reg_idx_t rd,
    input  reg_idx_t rs1,
    input  reg_idx_t rs2,
    input  word_t    w_data,
    output word_t    rs1_data,
    output word_t    rs2_data
);

    word_t regs [reg_count];
    logic  wr_ok;

    // Write only to real, non-zero registers
    assign wr_ok = wen && (rd != '0) && (int'(rd) < reg_count);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_ok) begin
            regs[rd] <= w_data;
        end
    end

    // Reads see the value before this cycle's write
    // x0 is read from storage, its zero comes from reset and the write gate
    assign rs1_data = (int'(rs1) < reg_count) ? regs[rs1] : '0;
    assign rs2_data = (int'(rs2) < reg_count) ? regs[rs2] : '0;

    // x0 stays zero even right after a writeback aimed at it
    assert property (@(posedge CLK) disable iff (!nRST)
        (rs1 == '0) |-> (rs1_data == '0));
    assert property (@(posedge CLK) disable iff (!nRST)
        (rs2 == '0) |-> (rs2_data == '0));

endmodule

/* operand_select.sv */
// Operand muxing; one forwarded value serves both sources, flags come from an outside unit
module operand_select import exec_pkg::*; (
    decode_if.operands dec,
    input  word_t      rs1_data,
    input  word_t      rs2_data,
    input  word_t      pc,
    input  word_t      fwd_data,
    input  logic       fwd_rs1,
    input  logic       fwd_rs2,
    output word_t      rs1_val,
    output word_t      rs2_val,
    output word_t      port_a,
    output word_t      port_b
);

    // Memory-stage value overrides the stale register read
    assign rs1_val = fwd_rs1 ? fwd_data : rs1_data;
    assign rs2_val = fwd_rs2 ? fwd_data : rs2_data;

    // Operand A
    always_comb begin
        case (dec.a_sel)
            a_rs1:   port_a = rs1_val;
            a_pc:    port_a = pc;
            a_zero:  port_a = '0;
            default: port_a = '0;
        endcase
    end

    // Operand B
    always_comb begin
        case (dec.b_sel)
            b_rs2:   port_b = rs2_val;
            b_imm_i: port_b = dec.imm_i;
            b_imm_s: port_b = dec.imm_s;
            b_imm_u: port_b = dec.imm_u;
            // Link address step for JAL and JALR
            b_four:  port_b = instr_bytes;
            default: port_b = '0;
        endcase
    end

endmodule

/* alu.sv */
// RV32I integer ALU, purely combinational; shift amount is the low five bits of operand B
module alu import exec_pkg::*; (
    decode_if.alu dec,
    input  word_t port_a,
    input  word_t port_b,
    output word_t result
);

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = port_b[4:0];
    assign lt_signed   = $signed(port_a) < $signed(port_b);
    assign lt_unsigned = port_a < port_b;

    always_comb begin
        case (dec.alu_op)
            alu_add:  result = port_a + port_b;
            alu_sub:  result = port_a - port_b;
            alu_sll:  result = port_a << shamt;
            // Compare results are zero-extended to a word
            alu_slt:  result = {31'b0, lt_signed};
            alu_sltu: result = {31'b0, lt_unsigned};
            alu_xor:  result = port_a ^ port_b;
            alu_srl:  result = port_a >> shamt;
            // Arithmetic shift keeps the sign
            alu_sra:  result = word_t'($signed(port_a) >>> shamt);
            alu_or:   result = port_a | port_b;
            alu_and:  result = port_a & port_b;
            default:  result = '0;
        endcase
    end

endmodule

/* branch_jump_unit.sv */
// Branch resolve and jump target; branch funct3 values 010 and 011 are never taken
module branch_jump_unit import exec_pkg::*; (
    decode_if.branch dec,
    input  word_t    rs1_val,
    input  word_t    rs2_val,
    input  word_t    pc,
    output logic     taken,
    output word_t    target
);

    logic  cond;
    word_t jalr_sum;

    // Comparison on the forwarded register values
    always_comb begin
        case (dec.branch_type)
            br_beq:  cond = (rs1_val == rs2_val);
            br_bne:  cond = (rs1_val != rs2_val);
            br_blt:  cond = ($signed(rs1_val) < $signed(rs2_val));
            br_bge:  cond = ($signed(rs1_val) >= $signed(rs2_val));
            br_bltu: cond = (rs1_val < rs2_val);
            br_bgeu: cond = (rs1_val >= rs2_val);
            default: cond = 1'b0;
        endcase
    end

    // Jumps always redirect
    assign taken = dec.is_branch ? cond : (dec.is_jal || dec.is_jalr);

    assign jalr_sum = rs1_val + dec.imm_i;

    // Next-PC choice, fall-through unless redirected
    always_comb begin
        if (dec.is_jal) begin
            target = pc + dec.imm_j;
        end else if (dec.is_jalr) begin
            // Bit zero of the JALR target is dropped
            target = jalr_sum & ~word_t'(1);
        end else if (dec.is_branch && cond) begin
            target = pc + dec.imm_b;
        end else begin
            target = pc + instr_bytes;
        end
    end

endmodule

/* ex_mem_register.sv */
// Execute-to-memory register; stall beats flush, illegal words keep valid but lose all control
module ex_mem_register import exec_pkg::*; (
    input  logic     CLK,
    input  logic     nRST,
    input  logic     stall,
    input  logic     flush,
    input  logic     in_valid,
    decode_if.pipe   dec,
    input  word_t    alu_result,
    input  word_t    rs2_val,
    input  logic     taken,
    input  word_t    target,
    input  word_t    pc,
    output logic     ex_valid,
    output logic     ex_reg_write,
    output logic     ex_dren,
    output logic     ex_dwen,
    output logic     ex_branch,
    output logic     ex_jump,
    output logic     ex_branch_taken,
    output logic     ex_illegal,
    output reg_idx_t ex_rd,
    output word_t    ex_alu_result,
    output word_t    ex_rs2_data,
    output word_t    ex_brj_addr,
    output word_t    ex_pc
);

    logic ok;

    // Control bits pass only for a legal instruction
    assign ok = !dec.illegal;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST || (flush && !stall)) begin
            ex_valid        <= 1'b0;
            ex_reg_write    <= 1'b0;
            ex_dren         <= 1'b0;
            ex_dwen         <= 1'b0;
            ex_branch       <= 1'b0;
            ex_jump         <= 1'b0;
            ex_branch_taken <= 1'b0;
            ex_illegal      <= 1'b0;
            ex_rd           <= '0;
            ex_alu_result   <= '0;
            ex_rs2_data     <= '0;
            ex_brj_addr     <= '0;
            ex_pc           <= '0;
        end else if (!stall) begin
            ex_valid        <= in_valid;
            ex_illegal      <= dec.illegal;
            ex_reg_write    <= ok && dec.reg_write;
            ex_dren         <= ok && dec.dren;
            ex_dwen         <= ok && dec.dwen;
            ex_branch       <= ok && dec.is_branch;
            ex_jump         <= ok && (dec.is_jal || dec.is_jalr);
            // Branch outcome only, jumps report through ex_jump
            ex_branch_taken <= ok && dec.is_branch && taken;
            ex_rd           <= dec.rd;
            ex_alu_result   <= alu_result;
            ex_rs2_data     <= rs2_val;
            ex_brj_addr     <= target;
            ex_pc           <= pc;
        end
    end

    // A flushed slot leaves no valid instruction behind
    assert property (@(posedge CLK) disable iff (!nRST)
        (flush && !stall) |=> !ex_valid);

    // Stall freezes the whole stage output
    assert property (@(posedge CLK) disable iff (!nRST)
        stall |=> $stable({ex_valid, ex_reg_write, ex_dren, ex_dwen, ex_branch, ex_jump,
                           ex_branch_taken, ex_illegal, ex_rd, ex_alu_result, ex_rs2_data,
                           ex_brj_addr, ex_pc}));

endmodule

/* execute_stage.sv */
// RV32I execute stage top; one-cycle latency, no memory access, forwarding flags set outside
module execute_stage import exec_pkg::*; #(
    parameter int reg_count = 32
) (
    input  logic     CLK,
    input  logic     nRST,
    input  logic     in_valid,
    input  word_t    instr,
    input  word_t    pc,
    input  logic     stall,
    input  logic     flush,
    input  logic     fwd_rs1,
    input  logic     fwd_rs2,
    input  word_t    fwd_data,
    input  logic     wb_en,
    input  reg_idx_t wb_rd,
    input  word_t    wb_data,
    output logic     ex_valid,
    output logic     ex_reg_write,
    output logic     ex_dren,
    output logic     ex_dwen,
    output logic     ex_branch,
    output logic     ex_jump,
    output logic     ex_branch_taken,
    output logic     ex_illegal,
    output reg_idx_t ex_rd,
    output word_t    ex_alu_result,
    output word_t    ex_rs2_data,
    output word_t    ex_brj_addr,
    output word_t    ex_pc,
    output reg_idx_t rs1_idx,
    output reg_idx_t rs2_idx
);

    decode_if dec_bus ();

    word_t rs1_data, rs2_data, rs1_val, rs2_val, port_a, port_b, alu_result, target;
    logic  taken;
    logic  rf_wen;

    // Source indices for an outside hazard unit
    assign rs1_idx = dec_bus.rs1;
    assign rs2_idx = dec_bus.rs2;

    // Writeback is held off while the stage stalls
    assign rf_wen = wb_en && !stall;

    control_decoder decoder_inst (.instr(instr), .dec(dec_bus));

    reg_file #(.reg_count(reg_count)) reg_file_inst (
        .CLK(CLK), .nRST(nRST), .wen(rf_wen), .rd(wb_rd), .rs1(dec_bus.rs1),
        .rs2(dec_bus.rs2), .w_data(wb_data), .rs1_data(rs1_data), .rs2_data(rs2_data)
    );

    operand_select operand_select_inst (
        .dec(dec_bus), .rs1_data(rs1_data), .rs2_data(rs2_data), .pc(pc), .fwd_data(fwd_data),
        .fwd_rs1(fwd_rs1), .fwd_rs2(fwd_rs2), .rs1_val(rs1_val), .rs2_val(rs2_val),
        .port_a(port_a), .port_b(port_b)
    );

    alu alu_inst (.dec(dec_bus), .port_a(port_a), .port_b(port_b), .result(alu_result));

    branch_jump_unit branch_jump_inst (
        .dec(dec_bus), .rs1_val(rs1_val), .rs2_val(rs2_val), .pc(pc), .taken(taken),
        .target(target)
    );

    ex_mem_register ex_mem_inst (
        .CLK(CLK), .nRST(nRST), .stall(stall), .flush(flush), .in_valid(in_valid),
        .dec(dec_bus), .alu_result(alu_result), .rs2_val(rs2_val), .taken(taken),
        .target(target), .pc(pc), .ex_valid(ex_valid), .ex_reg_write(ex_reg_write),
        .ex_dren(ex_dren), .ex_dwen(ex_dwen), .ex_branch(ex_branch), .ex_jump(ex_jump),
        .ex_branch_taken(ex_branch_taken), .ex_illegal(ex_illegal), .ex_rd(ex_rd),
        .ex_alu_result(ex_alu_result), .ex_rs2_data(ex_rs2_data),
        .ex_brj_addr(ex_brj_addr), .ex_pc(ex_pc)
    );

endmodule

/* tb_execute_stage.sv */
// Random execute stage testbench with a reference model; assumes reg_count 32 and stops at 3000 cycles
module tb_execute_stage import exec_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int timeout_cycles = 3000;

    // DUT inputs
    logic     CLK, nRST, in_valid, stall, flush, fwd_rs1, fwd_rs2, wb_en;
    word_t    instr, pc, fwd_data, wb_data;
    reg_idx_t wb_rd;

    // DUT outputs
    logic     ex_valid, ex_reg_write, ex_dren, ex_dwen, ex_branch, ex_jump;
    logic     ex_branch_taken, ex_illegal;
    reg_idx_t ex_rd, rs1_idx, rs2_idx;
    word_t    ex_alu_result, ex_rs2_data, ex_brj_addr, ex_pc;

    // Stimulus for the coming cycle
    logic     s_valid, s_stall, s_flush, s_fwd1, s_fwd2, s_wben;
    word_t    s_instr, s_pc, s_fwdd, s_wbdata;
    reg_idx_t s_wbrd;

    // Expected pipeline register after the next edge
    logic     e_valid, e_reg_write, e_dren, e_dwen, e_branch, e_jump, e_taken, e_illegal;
    logic     e_alu_chk;
    reg_idx_t e_rd;
    word_t    e_alu, e_rs2, e_brj, e_pc;

    // Architectural register model
    word_t  model_regs [32];
    integer seed = 28466;
    int     cycle_count = 0;

    execute_stage #(.reg_count(32)) execute_stage_inst (.*);

    initial begin
        CLK = 1'b0;
        forever begin
            #50 CLK = ~CLK;
        end
    end

    function automatic word_t rnd();
        return $random(seed);
    endfunction

    // Uniform pick in 0 .. n-1
    function automatic int pick(int n);
        word_t r;
        r = rnd();
        return int'(r % word_t'(n));
    endfunction

    function automatic logic legal_opcode(logic [6:0] o);
        case (o)
            7'b0000011, 7'b0010011, 7'b0010111, 7'b0100011, 7'b0110011,
            7'b0110111, 7'b1100011, 7'b1100111, 7'b1101111: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    // RV32I arithmetic by funct3, alt selects sub or sra
    function automatic word_t alu_ref(logic [2:0] f3, logic alt, word_t a, word_t b);
        word_t sra;
        sra = $signed(a) >>> b[4:0];
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    return (a < b) ? 32'd1 : 32'd0;
            3'd4:    return a ^ b;
            3'd5:    return alt ? sra : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_ref(logic [2:0] f3, word_t a, word_t b);
        case (f3)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return $signed(a) < $signed(b);
            3'd5:    return $signed(a) >= $signed(b);
            3'd6:    return a < b;
            3'd7:    return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    // Class 0 OP, 1 OP-IMM, 2 LUI, 3 AUIPC, 4 load, 5 store, 6 branch, 7 JAL, 8 JALR, else illegal
    function automatic word_t gen_instr(int cls);
        word_t      w;
        logic [6:0] opc;
        logic [2:0] br_f3 [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        w = rnd();
        case (cls)
            0: begin
                w[6:0]   = 7'b0110011;
                w[31:25] = ((w[14:12] == 3'd0 || w[14:12] == 3'd5) && w[30]) ? 7'h20 : 7'h00;
            end
            1: begin
                w[6:0] = 7'b0010011;
                // Shift immediates carry a proper funct7
                if (w[14:12] == 3'd1) begin
                    w[31:25] = 7'h00;
                end else if (w[14:12] == 3'd5) begin
                    w[31:25] = w[30] ? 7'h20 : 7'h00;
                end
            end
            2: w[6:0] = 7'b0110111;
            3: w[6:0] = 7'b0010111;
            4: w[6:0] = 7'b0000011;
            5: w[6:0] = 7'b0100011;
            6: begin
                w[6:0]   = 7'b1100011;
                w[14:12] = br_f3[pick(6)];
                // Same source twice now and then so equality comes up
                if (w[26:25] == 2'b00) begin
                    w[24:20] = w[19:15];
                end
            end
            7: w[6:0] = 7'b1101111;
            8: begin
                w[6:0]   = 7'b1100111;
                w[14:12] = 3'd0;
            end
            default: begin
                do begin
                    opc = 7'(rnd());
                end while (legal_opcode(opc));
                w[6:0] = opc;
            end
        endcase
        return w;
    endfunction

    task automatic check_word(string name, word_t expected, word_t actual);
        if (actual !== expected) begin
            $display("** Error at %0t: %s expected %h, actual %h", $time, name, expected, actual);
            $display("SOME TESTS FAILED");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic check_idx(string name, reg_idx_t expected, reg_idx_t actual);
        if (actual !== expected) begin
            $display("** Error at %0t: %s expected %0d, actual %0d", $time, name, expected, actual);
            $display("SOME TESTS FAILED");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic check_flag(string name, logic expected, logic actual);
        if (actual !== expected) begin
            $display("** Error at %0t: %s expected %b, actual %b", $time, name, expected, actual);
            $display("SOME TESTS FAILED");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic clear_expected();
        e_valid     = 1'b0;
        e_reg_write = 1'b0;
        e_dren      = 1'b0;
        e_dwen      = 1'b0;
        e_branch    = 1'b0;
        e_jump      = 1'b0;
        e_taken     = 1'b0;
        e_illegal   = 1'b0;
        e_alu_chk   = 1'b1;
        e_rd        = '0;
        e_alu       = '0;
        e_rs2       = '0;
        e_brj       = '0;
        e_pc        = '0;
    endtask

    task automatic check_outputs();
        check_flag("ex_valid", e_valid, ex_valid);
        check_flag("ex_reg_write", e_reg_write, ex_reg_write);
        check_flag("ex_dren", e_dren, ex_dren);
        check_flag("ex_dwen", e_dwen, ex_dwen);
        check_flag("ex_branch", e_branch, ex_branch);
        check_flag("ex_jump", e_jump, ex_jump);
        check_flag("ex_branch_taken", e_taken, ex_branch_taken);
        check_flag("ex_illegal", e_illegal, ex_illegal);
        check_idx("ex_rd", e_rd, ex_rd);
        // Branch and illegal words leave the ALU result undefined
        if (e_alu_chk) begin
            check_word("ex_alu_result", e_alu, ex_alu_result);
        end
        check_word("ex_rs2_data", e_rs2, ex_rs2_data);
        check_word("ex_brj_addr", e_brj, ex_brj_addr);
        check_word("ex_pc", e_pc, ex_pc);
    endtask

    // Model of one cycle: reads see old register values, then writeback lands
    task automatic predict();
        word_t      rv1, rv2, imm_i, imm_s, imm_b, imm_u, imm_j, res, tgt;
        logic [2:0] f3;
        logic       rw, rden, wren, br, jmp, ill, cond, chk;
        f3    = s_instr[14:12];
        rv1   = s_fwd1 ? s_fwdd : model_regs[s_instr[19:15]];
        rv2   = s_fwd2 ? s_fwdd : model_regs[s_instr[24:20]];
        imm_i = {{20{s_instr[31]}}, s_instr[31:20]};
        imm_s = {{20{s_instr[31]}}, s_instr[31:25], s_instr[11:7]};
        imm_b = {{20{s_instr[31]}}, s_instr[7], s_instr[30:25], s_instr[11:8], 1'b0};
        imm_u = {s_instr[31:12], 12'h000};
        imm_j = {{12{s_instr[31]}}, s_instr[19:12], s_instr[20], s_instr[30:21], 1'b0};
        rw    = 1'b0;
        rden  = 1'b0;
        wren  = 1'b0;
        br    = 1'b0;
        jmp   = 1'b0;
        ill   = 1'b0;
        cond  = 1'b0;
        chk   = 1'b1;
        res   = '0;
        // Fall-through unless redirected
        tgt   = s_pc + 32'd4;
        case (s_instr[6:0])
            7'b0110011: begin
                rw  = 1'b1;
                res = alu_ref(f3, s_instr[30], rv1, rv2);
            end
            7'b0010011: begin
                rw  = 1'b1;
                res = alu_ref(f3, s_instr[30] && (f3 == 3'd5), rv1, imm_i);
            end
            7'b0110111: begin
                rw  = 1'b1;
                res = imm_u;
            end
            7'b0010111: begin
                rw  = 1'b1;
                res = s_pc + imm_u;
            end
            7'b0000011: begin
                rw   = 1'b1;
                rden = 1'b1;
                res  = rv1 + imm_i;
            end
            7'b0100011: begin
                wren = 1'b1;
                res  = rv1 + imm_s;
            end
            7'b1101111: begin
                rw  = 1'b1;
                jmp = 1'b1;
                res = s_pc + 32'd4;
                tgt = s_pc + imm_j;
            end
            7'b1100111: begin
                rw  = 1'b1;
                jmp = 1'b1;
                res = s_pc + 32'd4;
                tgt = (rv1 + imm_i) & ~32'd1;
            end
            7'b1100011: begin
                br   = 1'b1;
                chk  = 1'b0;
                cond = branch_ref(f3, rv1, rv2);
                if (cond) begin
                    tgt = s_pc + imm_b;
                end
            end
            default: begin
                ill = 1'b1;
                chk = 1'b0;
            end
        endcase
        // Stall holds, flush clears, otherwise load
        if (!s_stall) begin
            if (s_flush) begin
                clear_expected();
            end else begin
                e_valid     = s_valid;
                e_reg_write = rw;
                e_dren      = rden;
                e_dwen      = wren;
                e_branch    = br;
                e_jump      = jmp;
                e_taken     = br && cond;
                e_illegal   = ill;
                e_alu_chk   = chk;
                e_rd        = s_instr[11:7];
                e_alu       = res;
                e_rs2       = rv2;
                e_brj       = tgt;
                e_pc        = s_pc;
            end
        end
        if (s_wben && !s_stall && s_wbrd != '0) begin
            model_regs[s_wbrd] = s_wbdata;
        end
    endtask

    // Plain valid instruction, no forwarding, stall, flush or writeback
    task automatic new_instruction(int cls);
        s_valid  = 1'b1;
        s_instr  = gen_instr(cls);
        s_pc     = rnd() & ~32'd3;
        s_stall  = 1'b0;
        s_flush  = 1'b0;
        s_fwd1   = 1'b0;
        s_fwd2   = 1'b0;
        s_fwdd   = rnd();
        s_wben   = 1'b0;
        s_wbrd   = reg_idx_t'(pick(32));
        s_wbdata = rnd();
    endtask

    // Drive at the edge, check the previous cycle's capture once settled
    task automatic step();
        @(posedge CLK);
        in_valid <= s_valid;
        instr    <= s_instr;
        pc       <= s_pc;
        stall    <= s_stall;
        flush    <= s_flush;
        fwd_rs1  <= s_fwd1;
        fwd_rs2  <= s_fwd2;
        fwd_data <= s_fwdd;
        wb_en    <= s_wben;
        wb_rd    <= s_wbrd;
        wb_data  <= s_wbdata;
        @(negedge CLK);
        check_outputs();
        check_idx("rs1_idx", s_instr[19:15], rs1_idx);
        check_idx("rs2_idx", s_instr[24:20], rs2_idx);
        predict();
    endtask

    initial begin
        nRST     = 1'b0;
        in_valid = 1'b0;
        instr    = '0;
        pc       = '0;
        stall    = 1'b0;
        // First edge after reset captures a flush, outputs stay zero
        flush    = 1'b1;
        fwd_rs1  = 1'b0;
        fwd_rs2  = 1'b0;
        fwd_data = '0;
        wb_en    = 1'b0;
        wb_rd    = '0;
        wb_data  = '0;
        foreach (model_regs[i]) begin
            model_regs[i] = '0;
        end
        clear_expected();
        repeat (8) @(posedge CLK);
        nRST <= 1'b1;
        @(negedge CLK);
        check_outputs();

        // Fill x1 to x31 through writeback
        for (int i = 1; i < 32; i++) begin
            new_instruction(pick(6));
            s_wben   = 1'b1;
            s_wbrd   = reg_idx_t'(i);
            step();
        end

        // Arithmetic, loads and stores with occasional writeback
        repeat (1500) begin
            new_instruction(pick(6));
            s_wben = pick(4) == 0;
            step();
        end

        // Mostly branches, some JAL and JALR
        repeat (400) begin
            new_instruction((pick(4) == 0) ? 7 + pick(2) : 6);
            s_wben = pick(4) == 0;
            step();
        end

        // Forwarded operands, small values now and then for equal compares
        repeat (200) begin
            new_instruction(pick(9));
            s_fwd1 = pick(2) == 0;
            s_fwd2 = pick(2) == 0;
            if (pick(4) == 0) begin
                s_fwdd = word_t'(pick(4));
            end
            s_wben = pick(3) == 0;
            step();
        end

        // Random stall and flush mixed with writeback
        repeat (150) begin
            new_instruction(pick(9));
            s_stall = pick(3) == 0;
            s_flush = pick(4) == 0;
            s_wben  = pick(2) == 0;
            step();
        end

        // Writeback to x5 under stall is dropped, next read sees the old value
        new_instruction(0);
        s_stall = 1'b1;
        s_wben  = 1'b1;
        s_wbrd  = 5'd5;
        step();
        new_instruction(0);
        s_instr[19:15] = 5'd5;
        step();

        // Illegal opcodes with random valid
        repeat (100) begin
            new_instruction(9);
            s_valid = pick(2) == 0;
            step();
        end

        // One more cycle checks the last capture
        new_instruction(0);
        step();
        $display("ALL TESTS PASSED");
        $finish;
    end

    // Run limit, the test needs about 2400 cycles
    initial begin
        while (cycle_count < timeout_cycles) begin
            @(posedge CLK);
            cycle_count++;
        end
        $display("Timeout: the test did not finish within %0d cycles", timeout_cycles);
        $display("SOME TESTS FAILED");
        $fatal(1, "Run stopped by timeout");
    end

endmodule

/* sources.f */
exec_pkg.sv
decode_if.sv
control_decoder.sv
reg_file.sv
operand_select.sv
alu.sv
branch_jump_unit.sv
ex_mem_register.sv
execute_stage.sv
tb_execute_stage.sv

/* Makefile */
RTL = exec_pkg.sv decode_if.sv control_decoder.sv reg_file.sv operand_select.sv \
      alu.sv branch_jump_unit.sv ex_mem_register.sv execute_stage.sv

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --top-module execute_stage $(RTL)

sim:
	verilator --binary --timing --top-module tb_execute_stage -f sources.f
	./obj_dir/Vtb_execute_stage

clean:
	rm -rf obj_dir
